// ==== Bender.yml ====
package:
  name: be_commit_tracer

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/be_instr_pkg.sv
      - hw/trace_pkg.sv
      - hw/delay_line.sv
      - hw/host_call_decode.sv
      - hw/commit_encode.sv
      - hw/trace_ctrl.sv
      - hw/be_commit_tracer_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/be_trace_checker.sv
      - bench/tb_be_commit_tracer.sv

// ==== bench/be_trace_checker.sv ====
`timescale 1ns/1ps
`include "be_trace_params.svh"

module be_trace_checker (
   input logic                 clk_i,
   input logic                 rst_n_i,
   input logic                 booted_i,
   input logic                 cmt_v_i,
   input trace_pkg::op_class_e cmt_op_i,
   input logic                 host_v_i,
   input logic                 iwb_instr_v_i,
   input logic                 iwb_poison_i
);

   import trace_pkg::*;

   // Failure count, read by the testbench at the end of the run
   int   assert_fail_cnt = 0;
   logic iwb_commit_ok;

   assign iwb_commit_ok = iwb_instr_v_i & ~iwb_poison_i;

   cmt_needs_boot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      cmt_v_i |-> booted_i)
      else begin
         $error("commit strobe high while the boot flag is low");
         assert_fail_cnt++;
      end

   host_needs_store: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      host_v_i |-> (cmt_v_i && cmt_op_i == OP_STORE))
      else begin
         $error("host strobe without a committed store");
         assert_fail_cnt++;
      end

   // Back-to-back commits need an eligible IWB packet in both cycles before
   cmt_back_to_back: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      (cmt_v_i && $past(cmt_v_i)) |-> ($past(iwb_commit_ok) && $past(iwb_commit_ok, 2)))
      else begin
         $error("consecutive commits without a valid unpoisoned IWB packet");
         assert_fail_cnt++;
      end

endmodule

bind be_commit_tracer_top be_trace_checker u_trace_checker (
   .clk_i         (clk_i),
   .rst_n_i       (rst_n_i),
   .booted_i      (u_ctrl.booted_r),
   .cmt_v_i       (cmt_v_o),
   .cmt_op_i      (cmt_op_o),
   .host_v_i      (host_v_o),
   .iwb_instr_v_i (stage_pkts[`BE_CMT_STAGE].decode.instr_v),
   .iwb_poison_i  (poison_i[`BE_CMT_STAGE])
);

// ==== bench/tb_be_commit_tracer.sv ====
`timescale 1ns/1ps
`include "be_trace_params.svh"

module tb_be_commit_tracer;

   import trace_pkg::*;

   // Each record holds 17 inputs then 17 expected outputs
   localparam int NF         = 34;
   localparam int MAX_REC    = 32;
   localparam int RST_CYCLES = 10;
   localparam logic [63:0] END_ID = 64'hff;

   logic                                   clk_i;
   logic                                   rst_n_i;
   logic                                   issue_v_i;
   logic [`BE_PC_W-1:0]                    issue_pc_i;
   logic                                   disp_instr_v_i;
   logic                                   disp_csr_i;
   logic                                   disp_ret_i;
   logic                                   disp_load_i;
   logic                                   disp_store_i;
   logic                                   disp_jmp_i;
   logic                                   disp_br_i;
   logic                                   disp_irf_w_i;
   logic [`BE_RADDR_W-1:0]                 disp_rd_addr_i;
   logic [`BE_RADDR_W-1:0]                 disp_rs2_addr_i;
   logic [`BE_PC_W-1:0]                    disp_pc_i;
   logic [`BE_ITAG_W-1:0]                  disp_itag_i;
   logic [`BE_INSTR_W-1:0]                 disp_instr_i;
   logic [`BE_REG_W-1:0]                   disp_rs1_i;
   logic [`BE_REG_W-1:0]                   disp_rs2_i;
   logic [`BE_REG_W-1:0]                   disp_imm_i;
   logic                                   fe_nop_i;
   logic                                   be_nop_i;
   logic                                   me_nop_i;
   logic [`BE_TRACE_STAGES-1:0]            roll_i;
   logic [`BE_TRACE_STAGES-1:0]            poison_i;
   logic [`BE_REG_W-1:0]                   ex1_br_tgt_i;
   logic [`BE_REG_W-1:0]                   iwb_result_i;
   logic                                   stat_v_o;
   logic                                   iss_v_o;
   logic [`BE_PC_W-1:0]                    iss_pc_o;
   stage_status_e                          isd_status_o;
   logic [`BE_PC_W-1:0]                    isd_pc_o;
   stage_status_e [`BE_TRACE_STAGES-1:0]   stage_status_o;
   logic [`BE_TRACE_STAGES-1:0][`BE_PC_W-1:0] stage_pc_o;
   logic                                   cmt_v_o;
   logic [`BE_PC_W-1:0]                    cmt_pc_o;
   logic [`BE_ITAG_W-1:0]                  cmt_itag_o;
   logic [`BE_INSTR_W-1:0]                 cmt_instr_o;
   op_class_e                              cmt_op_o;
   logic [`BE_RADDR_W-1:0]                 cmt_reg_o;
   logic [`BE_REG_W-1:0]                   cmt_addr_o;
   logic [`BE_REG_W-1:0]                   cmt_data_o;
   logic                                   host_v_o;
   host_evt_e                              host_evt_o;
   logic [15:0]                            host_code_o;

   logic [63:0] stim_mem [0:NF*MAX_REC-1];
   int          n_rec;
   int          cycle_cnt;
   int          cycle_limit = MAX_REC + RST_CYCLES + 20;

   be_commit_tracer_top i_be_commit_tracer_top (.*);

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   function automatic string test_name(input logic [63:0] id);
      string name;
      case (id)
         64'd1:   name = "boot";
         64'd2:   name = "stage_status";
         64'd3:   name = "commit_class";
         64'd4:   name = "jump_branch";
         64'd5:   name = "host_store";
         64'd6:   name = "poison_roll";
         default: name = "unknown";
      endcase
      return name;
   endfunction

   // Low width bits of word idx of record r
   // Records before the first read as zero since the shadow line clears on reset
   function automatic logic [63:0] stim_word(input int r, input int idx, input int width);
      logic [63:0] word;
      word = '0;
      if (r >= 0) begin
         word = stim_mem[r*NF+idx] & ((64'd1 << width) - 64'd1);
      end
      return word;
   endfunction

   task automatic abort_run(input string why);
      $display("%0s", why);
      $display("test failed");
      $fatal(1);
   endtask

   task automatic check_field(input int r, input string field,
                              input logic [63:0] exp_val, input logic [63:0] act_val);
      string msg;
      assert (act_val === exp_val) else begin
         msg = $sformatf("error %0s cycle %0d %0s expected %0h actual %0h",
                         test_name(stim_mem[r*NF]), r, field, exp_val, act_val);
         abort_run(msg);
      end
   endtask

   task automatic clear_inputs();
      issue_v_i    = 1'b0;
      issue_pc_i   = '0;
      {disp_instr_v_i, disp_csr_i, disp_ret_i, disp_load_i} = 4'b0;
      {disp_store_i, disp_jmp_i, disp_br_i, disp_irf_w_i}   = 4'b0;
      disp_rd_addr_i  = '0;
      disp_rs2_addr_i = '0;
      disp_pc_i       = '0;
      disp_itag_i     = '0;
      disp_instr_i    = '0;
      disp_rs1_i      = '0;
      disp_rs2_i      = '0;
      disp_imm_i      = '0;
      {fe_nop_i, be_nop_i, me_nop_i} = 3'b0;
      roll_i       = '0;
      poison_i     = '0;
      ex1_br_tgt_i = '0;
      iwb_result_i = '0;
   endtask

   // Records end at the END_ID marker
   task automatic load_stimulus();
      logic done;
      $readmemh("bench/trace_input.txt", stim_mem);
      n_rec = 0;
      done  = 1'b0;
      while (!done) begin
         if (n_rec == MAX_REC)
            done = 1'b1;
         else if ($isunknown(stim_mem[n_rec*NF]) || stim_mem[n_rec*NF] == END_ID)
            done = 1'b1;
         else
            n_rec++;
      end
      if (n_rec == 0) begin
         abort_run("stimulus file bench/trace_input.txt holds no records");
      end
   endtask

   task automatic apply_inputs(input int r);
      int base;
      base = r * NF;
      issue_v_i  = stim_mem[base+1][0];
      issue_pc_i = stim_mem[base+2][`BE_PC_W-1:0];
      {disp_instr_v_i, disp_csr_i, disp_ret_i, disp_load_i,
       disp_store_i, disp_jmp_i, disp_br_i, disp_irf_w_i} = stim_mem[base+3][7:0];
      disp_rd_addr_i  = stim_mem[base+4][`BE_RADDR_W-1:0];
      disp_rs2_addr_i = stim_mem[base+5][`BE_RADDR_W-1:0];
      disp_pc_i       = stim_mem[base+6][`BE_PC_W-1:0];
      disp_itag_i     = stim_mem[base+7][`BE_ITAG_W-1:0];
      disp_instr_i    = stim_mem[base+8][`BE_INSTR_W-1:0];
      disp_rs1_i      = stim_mem[base+9];
      disp_rs2_i      = stim_mem[base+10];
      disp_imm_i      = stim_mem[base+11];
      {fe_nop_i, be_nop_i, me_nop_i} = stim_mem[base+12][2:0];
      roll_i       = stim_mem[base+13][`BE_TRACE_STAGES-1:0];
      poison_i     = stim_mem[base+14][`BE_TRACE_STAGES-1:0];
      ex1_br_tgt_i = stim_mem[base+15];
      iwb_result_i = stim_mem[base+16];
   endtask

   // Outputs seen one cycle after record r was driven
   task automatic check_outputs(input int r);
      int          base;
      logic [63:0] mask;
      base = r * NF;
      mask = stim_mem[base+17];
      check_field(r, "stat_v", stim_mem[base+18], stat_v_o);
      check_field(r, "iss_v", stim_mem[base+19], iss_v_o);
      if (stim_mem[base+19][0]) begin
         check_field(r, "iss_pc", stim_word(r, 2, `BE_PC_W), iss_pc_o);
      end
      check_field(r, "isd_status", stim_mem[base+20], isd_status_o);
      check_field(r, "isd_pc", stim_word(r, 6, `BE_PC_W), isd_pc_o);
      for (int i = 0; i < `BE_TRACE_STAGES; i++) begin
         check_field(r, $sformatf("stage_status[%0d]", i),
                     stim_mem[base+21+i], stage_status_o[i]);
         // Stage i holds the packet dispatched i+1 cycles earlier
         check_field(r, $sformatf("stage_pc[%0d]", i),
                     stim_word(r - 1 - i, 6, `BE_PC_W), stage_pc_o[i]);
      end
      check_field(r, "cmt_v", stim_mem[base+25], cmt_v_o);
      check_field(r, "host_v", stim_mem[base+31], host_v_o);
      if (mask[0]) begin
         check_field(r, "cmt_op", stim_mem[base+26], cmt_op_o);
         check_field(r, "cmt_pc", stim_mem[base+27], cmt_pc_o);
         check_field(r, "cmt_addr", stim_mem[base+28], cmt_addr_o);
         check_field(r, "cmt_data", stim_mem[base+29], cmt_data_o);
         check_field(r, "cmt_reg", stim_mem[base+30], cmt_reg_o);
         // Committing packet was dispatched three cycles earlier
         check_field(r, "cmt_itag", stim_word(r - 3, 7, `BE_ITAG_W), cmt_itag_o);
         check_field(r, "cmt_instr", stim_word(r - 3, 8, `BE_INSTR_W), cmt_instr_o);
      end
      if (mask[1]) begin
         check_field(r, "host_evt", stim_mem[base+32], host_evt_o);
         check_field(r, "host_code", stim_mem[base+33], host_code_o);
      end
   endtask

   initial begin
      cycle_cnt = 0;
      forever begin
         @(posedge clk_i);
         cycle_cnt++;
         if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, stimulus did not finish",
                                cycle_cnt));
         end
      end
   end

   initial begin
      rst_n_i = 1'b0;
      clear_inputs();
      load_stimulus();
      // One cycle per record after reset plus a margin
      cycle_limit = n_rec + RST_CYCLES + 20;
      repeat (RST_CYCLES) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;
      apply_inputs(0);
      for (int r = 0; r < n_rec; r++) begin
         @(posedge clk_i);
         #1;
         check_outputs(r);
         if (r + 1 < n_rec) begin
            apply_inputs(r + 1);
         end
      end
      if (i_be_commit_tracer_top.u_trace_checker.assert_fail_cnt != 0) begin
         abort_run("a concurrent assertion in the trace checker failed");
      end else begin
         $display("test passed");
         $finish;
      end
   end

endmodule

// ==== bench/trace_input.txt ====
// In: id issue_v issue_pc flags rd rs2a pc itag instr rs1 rs2 imm nops roll poison br_tgt res
// Exp: mask stat iss isd st0 st1 st2 st3 cmt op pc addr data reg host_v evt code
// Boot: A dispatched before the first issue never commits
1 0 0 81 1 0 100 1 33 0 0 0 0 0 0 0 0
0 0 0 0 1 1 1 1 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 1 1 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 1 0 1 1 0 0 0 0 0 0 0 0 0
1 1 200 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 1 1 0 1 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
0 1 0 0 1 1 1 0 0 0 0 0 0 0 0 0 0
// Bubble and roll/poison priorities
2 1 204 81 2 0 104 2 33 0 0 0 6 0 0 0 0
0 1 1 4 1 1 1 1 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 3 1 3 0 0
0 1 0 5 2 3 1 1 0 0 0 0 0 0 0 0 0
2 0 0 0 0 0 0 0 0 0 0 0 1 8 8 0 0
0 1 0 6 1 0 1 2 0 0 0 0 0 0 0 0 0
// Int, csr, ret, load and other commits
3 0 0 c1 3 0 108 3 73 0 0 0 0 0 0 0 1234abcd
1 1 0 0 1 1 0 1 1 6 104 0 1234abcd 2 0 0 0
3 0 0 a0 0 0 10c 4 73 0 0 0 0 0 0 0 0
0 1 0 0 0 1 1 0 0 0 0 0 0 0 0 0 0
3 0 0 91 4 0 110 5 03 1000 0 28 0 0 0 0 0
0 1 0 0 0 0 1 1 0 0 0 0 0 0 0 0 0
3 0 0 80 5 0 114 6 0f 0 0 0 0 0 0 0 c5a0
1 1 0 0 0 0 0 1 1 0 108 0 c5a0 3 0 0 0
3 0 0 85 1 0 118 7 6f 0 0 0 0 0 0 0 ffff
1 1 0 0 0 0 0 0 1 1 10c 0 0 0 0 0 0
3 0 0 82 0 0 11c 8 63 0 0 0 0 0 0 2000 55aa
1 1 0 0 0 0 0 0 1 2 110 1028 55aa 4 0 0 0
3 0 0 88 0 6 120 9 23 c00dea00 2a d0 0 0 0 3000 77
1 1 0 0 0 0 0 0 1 7 114 0 0 5 0 0 0
// Jump and branch with delayed targets
4 0 0 88 0 7 124 a 23 c00dea00 ffff0003 d0 0 0 0 0 11c
1 1 0 0 0 0 0 0 1 4 118 2000 11c 1 0 0 0
4 0 0 88 0 8 128 b 23 c00dea00 12340005 d0 0 0 0 0 3
1 1 0 0 0 0 0 0 1 5 11c 3000 1 0 0 0 0
// Host pass, fail, error, hex, char and a plain store
5 0 0 88 0 9 12c c 23 8ffff000 1c5 fff 0 0 0 0 0
3 1 0 0 0 0 0 0 1 3 120 c00dead0 2a 6 1 1 2a
5 0 0 88 0 a 130 d 23 8fffe000 41 fff 0 0 0 0 0
3 1 0 0 0 0 0 0 1 3 124 c00dead0 ffff0003 7 1 2 3
5 0 0 88 0 b 134 e 23 4000 deadbeef 10 0 0 0 0 0
3 1 0 0 0 0 0 0 1 3 128 c00dead0 12340005 8 1 3 0
5 0 0 81 c 0 138 f 33 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 1 3 12c 8fffffff 1c5 9 1 4 c5
5 0 0 81 d 0 13c 10 33 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 1 3 130 8fffefff 41 a 1 5 41
5 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
3 1 0 0 0 0 0 0 1 3 134 4010 deadbeef b 0 0 0
// Poisoned IWB drops the commit, rolled IWB keeps it
6 0 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0
0 1 0 0 1 0 3 0 0 0 0 0 0 0 0 0 0
6 0 0 0 0 0 0 0 0 0 0 0 0 4 0 0 99
1 1 0 0 1 1 2 0 1 6 13c 0 99 d 0 0 0
ff

// ==== hw/be_commit_tracer_top.sv ====
`timescale 1ns/1ps
`include "be_trace_params.svh"

module be_commit_tracer_top (
   input  logic                                            clk_i,
   input  logic                                            rst_n_i,
   input  logic                                            issue_v_i,
   input  logic [`BE_PC_W-1:0]                             issue_pc_i,
   input  logic                                            disp_instr_v_i,
   input  logic                                            disp_csr_i,
   input  logic                                            disp_ret_i,
   input  logic                                            disp_load_i,
   input  logic                                            disp_store_i,
   input  logic                                            disp_jmp_i,
   input  logic                                            disp_br_i,
   input  logic                                            disp_irf_w_i,
   input  logic [`BE_RADDR_W-1:0]                          disp_rd_addr_i,
   input  logic [`BE_RADDR_W-1:0]                          disp_rs2_addr_i,
   input  logic [`BE_PC_W-1:0]                             disp_pc_i,
   input  logic [`BE_ITAG_W-1:0]                           disp_itag_i,
   input  logic [`BE_INSTR_W-1:0]                          disp_instr_i,
   input  logic [`BE_REG_W-1:0]                            disp_rs1_i,
   input  logic [`BE_REG_W-1:0]                            disp_rs2_i,
   input  logic [`BE_REG_W-1:0]                            disp_imm_i,
   input  logic                                            fe_nop_i,
   input  logic                                            be_nop_i,
   input  logic                                            me_nop_i,
   input  logic [`BE_TRACE_STAGES-1:0]                     roll_i,
   input  logic [`BE_TRACE_STAGES-1:0]                     poison_i,
   input  logic [`BE_REG_W-1:0]                            ex1_br_tgt_i,
   input  logic [`BE_REG_W-1:0]                            iwb_result_i,
   output logic                                            stat_v_o,
   output logic                                            iss_v_o,
   output logic [`BE_PC_W-1:0]                             iss_pc_o,
   output trace_pkg::stage_status_e                        isd_status_o,
   output logic [`BE_PC_W-1:0]                             isd_pc_o,
   output trace_pkg::stage_status_e [`BE_TRACE_STAGES-1:0] stage_status_o,
   output logic [`BE_TRACE_STAGES-1:0][`BE_PC_W-1:0]       stage_pc_o,
   output logic                                            cmt_v_o,
   output logic [`BE_PC_W-1:0]                             cmt_pc_o,
   output logic [`BE_ITAG_W-1:0]                           cmt_itag_o,
   output logic [`BE_INSTR_W-1:0]                          cmt_instr_o,
   output trace_pkg::op_class_e                            cmt_op_o,
   output logic [`BE_RADDR_W-1:0]                          cmt_reg_o,
   output logic [`BE_REG_W-1:0]                            cmt_addr_o,
   output logic [`BE_REG_W-1:0]                            cmt_data_o,
   output logic                                            host_v_o,
   output trace_pkg::host_evt_e                            host_evt_o,
   output logic [15:0]                                     host_code_o
);

   import be_instr_pkg::*;
   import trace_pkg::*;

   dispatch_pkt_s                               disp_pkt;
   dispatch_pkt_s [`BE_TRACE_STAGES-1:0]        stage_pkts;
   logic [`BE_BR_TGT_DELAY-1:0][`BE_REG_W-1:0] br_tgt_taps;
   logic [`BE_REG_W-1:0]                        eaddr;
   host_evt_e                                   host_evt;
   logic [15:0]                                 host_code;
   op_class_e                                   op;
   logic [`BE_REG_W-1:0]                        addr;
   logic [`BE_REG_W-1:0]                        data;
   logic [`BE_RADDR_W-1:0]                      rd_reg;

   assign disp_pkt.decode.instr_v  = disp_instr_v_i;
   assign disp_pkt.decode.csr_v    = disp_csr_i;
   assign disp_pkt.decode.ret_v    = disp_ret_i;
   assign disp_pkt.decode.load_v   = disp_load_i;
   assign disp_pkt.decode.store_v  = disp_store_i;
   assign disp_pkt.decode.jmp_v    = disp_jmp_i;
   assign disp_pkt.decode.br_v     = disp_br_i;
   assign disp_pkt.decode.irf_w_v  = disp_irf_w_i;
   assign disp_pkt.decode.rd_addr  = disp_rd_addr_i;
   assign disp_pkt.decode.rs2_addr = disp_rs2_addr_i;
   assign disp_pkt.pc              = disp_pc_i;
   assign disp_pkt.itag            = disp_itag_i;
   assign disp_pkt.instr           = disp_instr_i;
   assign disp_pkt.rs1             = disp_rs1_i;
   assign disp_pkt.rs2             = disp_rs2_i;
   assign disp_pkt.imm             = disp_imm_i;

   // Shadow of EX1..FWB
   delay_line #(.T(dispatch_pkt_s), .DEPTH(`BE_TRACE_STAGES)) u_stage_line (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (disp_pkt),
      .taps_o  (stage_pkts)
   );

   // Last tap lines up with IWB
   delay_line #(.T(logic [`BE_REG_W-1:0]), .DEPTH(`BE_BR_TGT_DELAY)) u_br_tgt_line (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .data_i  (ex1_br_tgt_i),
      .taps_o  (br_tgt_taps)
   );

   host_call_decode u_host (
      .instr_v_i   (stage_pkts[`BE_CMT_STAGE].decode.instr_v),
      .store_i     (stage_pkts[`BE_CMT_STAGE].decode.store_v),
      .rs1_i       (stage_pkts[`BE_CMT_STAGE].rs1),
      .imm_i       (stage_pkts[`BE_CMT_STAGE].imm),
      .rs2_i       (stage_pkts[`BE_CMT_STAGE].rs2),
      .eaddr_o     (eaddr),
      .host_evt_o  (host_evt),
      .host_code_o (host_code)
   );

   commit_encode u_encode (
      .pkt_i        (stage_pkts[`BE_CMT_STAGE]),
      .eaddr_i      (eaddr),
      .br_tgt_i     (br_tgt_taps[`BE_BR_TGT_DELAY-1]),
      .iwb_result_i (iwb_result_i),
      .op_o         (op),
      .addr_o       (addr),
      .data_o       (data),
      .reg_o        (rd_reg)
   );

   trace_ctrl u_ctrl (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .issue_v_i      (issue_v_i),
      .issue_pc_i     (issue_pc_i),
      .disp_pkt_i     (disp_pkt),
      .stage_pkts_i   (stage_pkts),
      .fe_nop_i       (fe_nop_i),
      .be_nop_i       (be_nop_i),
      .me_nop_i       (me_nop_i),
      .roll_i         (roll_i),
      .poison_i       (poison_i),
      .op_i           (op),
      .addr_i         (addr),
      .data_i         (data),
      .reg_i          (rd_reg),
      .host_evt_i     (host_evt),
      .host_code_i    (host_code),
      .stat_v_o       (stat_v_o),
      .iss_v_o        (iss_v_o),
      .iss_pc_o       (iss_pc_o),
      .isd_status_o   (isd_status_o),
      .isd_pc_o       (isd_pc_o),
      .stage_status_o (stage_status_o),
      .stage_pc_o     (stage_pc_o),
      .cmt_v_o        (cmt_v_o),
      .cmt_pc_o       (cmt_pc_o),
      .cmt_itag_o     (cmt_itag_o),
      .cmt_instr_o    (cmt_instr_o),
      .cmt_op_o       (cmt_op_o),
      .cmt_reg_o      (cmt_reg_o),
      .cmt_addr_o     (cmt_addr_o),
      .cmt_data_o     (cmt_data_o),
      .host_v_o       (host_v_o),
      .host_evt_o     (host_evt_o),
      .host_code_o    (host_code_o)
   );

endmodule

// ==== hw/be_instr_pkg.sv ====
`include "be_trace_params.svh"

package be_instr_pkg;

   // Decode flags that travel with each dispatched instruction
   typedef struct packed {
      logic                   instr_v;
      logic                   csr_v;
      logic                   ret_v;
      logic                   load_v;
      logic                   store_v;
      logic                   jmp_v;
      logic                   br_v;
      logic                   irf_w_v;
      logic [`BE_RADDR_W-1:0] rd_addr;
      logic [`BE_RADDR_W-1:0] rs2_addr;
   } decode_s;

   // Full dispatch packet, operands already read
   typedef struct packed {
      decode_s                decode;
      logic [`BE_PC_W-1:0]    pc;
      logic [`BE_ITAG_W-1:0]  itag;
      logic [`BE_INSTR_W-1:0] instr;
      logic [`BE_REG_W-1:0]   rs1;
      logic [`BE_REG_W-1:0]   rs2;
      logic [`BE_REG_W-1:0]   imm;
   } dispatch_pkt_s;

endpackage

// ==== hw/commit_encode.sv ====
`timescale 1ns/1ps
`include "be_trace_params.svh"

module commit_encode (
   input  be_instr_pkg::dispatch_pkt_s pkt_i,
   input  logic [`BE_REG_W-1:0]        eaddr_i,
   input  logic [`BE_REG_W-1:0]        br_tgt_i,
   input  logic [`BE_REG_W-1:0]        iwb_result_i,
   output trace_pkg::op_class_e        op_o,
   output logic [`BE_REG_W-1:0]        addr_o,
   output logic [`BE_REG_W-1:0]        data_o,
   output logic [`BE_RADDR_W-1:0]      reg_o
);

   import trace_pkg::*;

   // First matching flag wins
   always_comb begin
      if (pkt_i.decode.csr_v)
         op_o = OP_CSR;
      else if (pkt_i.decode.ret_v)
         op_o = OP_RET;
      else if (pkt_i.decode.load_v)
         op_o = OP_LOAD;
      else if (pkt_i.decode.store_v)
         op_o = OP_STORE;
      else if (pkt_i.decode.jmp_v)
         op_o = OP_JUMP;
      else if (pkt_i.decode.br_v)
         op_o = OP_BRANCH;
      else if (pkt_i.decode.irf_w_v)
         op_o = OP_INT;
      else
         op_o = OP_OTHER;
   end

   always_comb begin
      case (op_o)
         OP_LOAD, OP_STORE:  addr_o = eaddr_i;
         OP_JUMP, OP_BRANCH: addr_o = br_tgt_i;
         default:            addr_o = '0;
      endcase
   end

   always_comb begin
      case (op_o)
         OP_STORE:         data_o = pkt_i.rs2;
         // Branch result carries only the taken flag
         OP_BRANCH:        data_o = {{(`BE_REG_W-1){1'b0}}, iwb_result_i[0]};
         OP_RET, OP_OTHER: data_o = '0;
         default:          data_o = iwb_result_i;
      endcase
   end

   assign reg_o = (op_o == OP_STORE) ? pkt_i.decode.rs2_addr : pkt_i.decode.rd_addr;

endmodule

// ==== hw/delay_line.sv ====
`timescale 1ns/1ps

module delay_line #(
   parameter type T     = logic,
   parameter int  DEPTH = 2
) (
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  T             data_i,
   output T [DEPTH-1:0] taps_o
);

   // Tap 0 is one cycle behind the input, every tap stays visible
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         taps_o <= '0;
      end else begin
         taps_o[0] <= data_i;
         for (int i = 1; i < DEPTH; i++) begin
            taps_o[i] <= taps_o[i-1];
         end
      end
   end

endmodule

// ==== hw/host_call_decode.sv ====
`timescale 1ns/1ps
`include "be_trace_params.svh"

module host_call_decode (
   input  logic                 instr_v_i,
   input  logic                 store_i,
   input  logic [`BE_REG_W-1:0] rs1_i,
   input  logic [`BE_REG_W-1:0] imm_i,
   input  logic [`BE_REG_W-1:0] rs2_i,
   output logic [`BE_REG_W-1:0] eaddr_o,
   output trace_pkg::host_evt_e host_evt_o,
   output logic [15:0]          host_code_o
);

   import trace_pkg::*;

   logic st_v;

   assign eaddr_o = rs1_i + imm_i;
   assign st_v    = instr_v_i & store_i;

   always_comb begin
      host_evt_o  = HE_NONE;
      host_code_o = '0;
      if (st_v && eaddr_o == `BE_HOST_TEST_ADDR) begin
         // Upper half of the word separates pass from fail
         if (rs2_i[31:16] == 16'h0000) begin
            host_evt_o  = HE_PASS;
            host_code_o = rs2_i[15:0];
         end else if (rs2_i[31:16] == 16'hFFFF) begin
            host_evt_o  = HE_FAIL;
            host_code_o = rs2_i[15:0];
         end else begin
            host_evt_o = HE_ERR;
         end
      end else if (st_v && eaddr_o == `BE_HOST_HEX_ADDR) begin
         host_evt_o  = HE_HEX;
         host_code_o = {8'h00, rs2_i[7:0]};
      end else if (st_v && eaddr_o == `BE_HOST_CHAR_ADDR) begin
         host_evt_o  = HE_CHAR;
         host_code_o = {8'h00, rs2_i[7:0]};
      end
   end

endmodule

// ==== hw/trace_ctrl.sv ====
`timescale 1ns/1ps
`include "be_trace_params.svh"

module trace_ctrl (
   input  logic                                            clk_i,
   input  logic                                            rst_n_i,
   input  logic                                            issue_v_i,
   input  logic [`BE_PC_W-1:0]                             issue_pc_i,
   input  be_instr_pkg::dispatch_pkt_s                     disp_pkt_i,
   input  be_instr_pkg::dispatch_pkt_s [`BE_TRACE_STAGES-1:0] stage_pkts_i,
   input  logic                                            fe_nop_i,
   input  logic                                            be_nop_i,
   input  logic                                            me_nop_i,
   input  logic [`BE_TRACE_STAGES-1:0]                     roll_i,
   input  logic [`BE_TRACE_STAGES-1:0]                     poison_i,
   input  trace_pkg::op_class_e                            op_i,
   input  logic [`BE_REG_W-1:0]                            addr_i,
   input  logic [`BE_REG_W-1:0]                            data_i,
   input  logic [`BE_RADDR_W-1:0]                          reg_i,
   input  trace_pkg::host_evt_e                            host_evt_i,
   input  logic [15:0]                                     host_code_i,
   output logic                                            stat_v_o,
   output logic                                            iss_v_o,
   output logic [`BE_PC_W-1:0]                             iss_pc_o,
   output trace_pkg::stage_status_e                        isd_status_o,
   output logic [`BE_PC_W-1:0]                             isd_pc_o,
   output trace_pkg::stage_status_e [`BE_TRACE_STAGES-1:0] stage_status_o,
   output logic [`BE_TRACE_STAGES-1:0][`BE_PC_W-1:0]       stage_pc_o,
   output logic                                            cmt_v_o,
   output logic [`BE_PC_W-1:0]                             cmt_pc_o,
   output logic [`BE_ITAG_W-1:0]                           cmt_itag_o,
   output logic [`BE_INSTR_W-1:0]                          cmt_instr_o,
   output trace_pkg::op_class_e                            cmt_op_o,
   output logic [`BE_RADDR_W-1:0]                          cmt_reg_o,
   output logic [`BE_REG_W-1:0]                            cmt_addr_o,
   output logic [`BE_REG_W-1:0]                            cmt_data_o,
   output logic                                            host_v_o,
   output trace_pkg::host_evt_e                            host_evt_o,
   output logic [15:0]                                     host_code_o
);

   import trace_pkg::*;

   logic                                 booted_r;
   logic                                 commit;
   stage_status_e                        isd_status;
   stage_status_e [`BE_TRACE_STAGES-1:0] stage_status;

   // Set by the first issue, held until reset
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         booted_r <= 1'b0;
      end else if (issue_v_i) begin
         booted_r <= 1'b1;
      end
   end

   always_comb begin
      if (fe_nop_i)
         isd_status = ST_BUB_FE;
      else if (be_nop_i)
         isd_status = ST_BUB_BE;
      else if (me_nop_i)
         isd_status = ST_BUB_ME;
      else
         isd_status = ST_VALID;
   end

   always_comb begin
      for (int i = 0; i < `BE_TRACE_STAGES; i++) begin
         if (roll_i[i])
            stage_status[i] = ST_ROLLED;
         else if (poison_i[i])
            stage_status[i] = ST_POISONED;
         else if (!stage_pkts_i[i].decode.instr_v)
            stage_status[i] = ST_NOP;
         else
            stage_status[i] = ST_VALID;
      end
   end

   // Roll at IWB does not block retirement, poison does
   assign commit = booted_r & stage_pkts_i[`BE_CMT_STAGE].decode.instr_v
                 & ~poison_i[`BE_CMT_STAGE];

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         stat_v_o <= 1'b0;
         iss_v_o  <= 1'b0;
         cmt_v_o  <= 1'b0;
         host_v_o <= 1'b0;
      end else begin
         stat_v_o <= booted_r;
         iss_v_o  <= booted_r & issue_v_i;
         cmt_v_o  <= commit;
         host_v_o <= commit & (op_i == OP_STORE) & (host_evt_i != HE_NONE);
      end
   end

   // Record fields, qualified by the strobes above
   always_ff @(posedge clk_i) begin
      iss_pc_o       <= issue_pc_i;
      isd_status_o   <= isd_status;
      isd_pc_o       <= disp_pkt_i.pc;
      stage_status_o <= stage_status;
      for (int i = 0; i < `BE_TRACE_STAGES; i++) begin
         stage_pc_o[i] <= stage_pkts_i[i].pc;
      end
      cmt_pc_o    <= stage_pkts_i[`BE_CMT_STAGE].pc;
      cmt_itag_o  <= stage_pkts_i[`BE_CMT_STAGE].itag;
      cmt_instr_o <= stage_pkts_i[`BE_CMT_STAGE].instr;
      cmt_op_o    <= op_i;
      cmt_reg_o   <= reg_i;
      cmt_addr_o  <= addr_i;
      cmt_data_o  <= data_i;
      host_evt_o  <= host_evt_i;
      host_code_o <= host_code_i;
   end

endmodule

// ==== hw/trace_pkg.sv ====
package trace_pkg;

   // What a pipeline slot held in a given cycle
   typedef enum logic [2:0] {
      ST_VALID,
      ST_NOP,
      ST_ROLLED,
      ST_POISONED,
      ST_BUB_FE,
      ST_BUB_BE,
      ST_BUB_ME
   } stage_status_e;

   // Class of a committed instruction
   typedef enum logic [2:0] {
      OP_CSR,
      OP_RET,
      OP_LOAD,
      OP_STORE,
      OP_JUMP,
      OP_BRANCH,
      OP_INT,
      OP_OTHER
   } op_class_e;

   // Test-host calls seen on committed stores
   typedef enum logic [2:0] {
      HE_NONE,
      HE_PASS,
      HE_FAIL,
      HE_ERR,
      HE_HEX,
      HE_CHAR
   } host_evt_e;

endpackage

// ==== include/be_trace_params.svh ====
`ifndef BE_TRACE_PARAMS_SVH
`define BE_TRACE_PARAMS_SVH

// Datapath widths of the RV64 backend
`define BE_PC_W    39
`define BE_REG_W   64
`define BE_INSTR_W 32
`define BE_ITAG_W  8
`define BE_RADDR_W 5

// Shadow line after dispatch holds EX1, EX2, IWB, FWB
`define BE_TRACE_STAGES 4
`define BE_CMT_STAGE    2

// EX1 to IWB
`define BE_BR_TGT_DELAY 2

// Test-host store addresses
`define BE_HOST_TEST_ADDR 64'h0000_0000_C00D_EAD0
`define BE_HOST_HEX_ADDR  64'h0000_0000_8FFF_FFFF
`define BE_HOST_CHAR_ADDR 64'h0000_0000_8FFF_EFFF

`endif

// ==== sources.f ====
+incdir+include
hw/be_instr_pkg.sv
hw/trace_pkg.sv
hw/delay_line.sv
hw/host_call_decode.sv
hw/commit_encode.sv
hw/trace_ctrl.sv
hw/be_commit_tracer_top.sv
bench/be_trace_checker.sv
bench/tb_be_commit_tracer.sv
